// ==== design/cache_macros.svh ====
// cache geometry and widths
// direct-mapped L1 data cache, 16 sets of 4-word lines,
// 32-bit words and byte addresses

`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// data and address
`define WORD_W          32
`define ADDR_W          32

// geometry
`define N_SETS          16
`define LINE_WORDS      4

// address field split: tag | index | word | byte
`define SET_BITS        4
`define WORD_SEL_BITS   2
`define BYTE_BITS       2
`define TAG_BITS        (`ADDR_W - `SET_BITS - `WORD_SEL_BITS - `BYTE_BITS)

// one select per byte lane
`define SEL_W           4

`endif

// ==== design/cache_pkg.sv ====
// cache types
// vector types for the split address fields and the
// controller state machine encoding

`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`WORD_W-1:0]        word_t;      // data word
    typedef logic [`ADDR_W-1:0]        addr_t;      // byte address
    typedef logic [`TAG_BITS-1:0]      tag_t;       // line tag
    typedef logic [`SET_BITS-1:0]      set_idx_t;   // set index
    typedef logic [`WORD_SEL_BITS-1:0] word_sel_t;  // word inside a line
    typedef logic [`SEL_W-1:0]         byte_sel_t;  // byte lane selects

    // controller states
    typedef enum logic [2:0] {
        INIT,       // clear sets after reset
        READY,      // serve hits, detect misses
        WRITEBACK,  // dirty victim out to memory
        REFILL,     // line in from memory
        FLUSH       // write back and invalidate all sets
    } cache_state_t;

endpackage

`default_nettype wire

// ==== design/cache_tag_store.sv ====
// cache tag store
// tag, valid and dirty bit for each set, read combinationally,
// and the hit compare against the lookup tag

`default_nettype none

`include "cache_macros.svh"

module cache_tag_store (
    input  logic                CLK,
    input  cache_pkg::set_idx_t index,
    input  cache_pkg::tag_t     lookup_tag,
    input  logic                wr_en,
    input  cache_pkg::tag_t     wr_tag,
    input  logic                wr_valid,
    input  logic                wr_dirty,
    output logic                hit,
    output cache_pkg::tag_t     line_tag,
    output logic                line_dirty
);

    cache_pkg::tag_t    tag_q [`N_SETS];
    logic [`N_SETS-1:0] valid_q;
    logic [`N_SETS-1:0] dirty_q;

    // all three fields of a set replaced together
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag_q[index]   <= wr_tag;
            valid_q[index] <= wr_valid;
            dirty_q[index] <= wr_dirty;
        end
    end

    assign line_tag   = tag_q[index];
    assign line_dirty = valid_q[index] & dirty_q[index]; // only a valid line can be dirty

    // hit needs a valid line with matching tag
    assign hit = valid_q[index] && (tag_q[index] == lookup_tag);

endmodule

`default_nettype wire

// ==== design/cache_data_store.sv ====
// cache data store
// 16 lines of 4 words, one word read combinationally,
// word writes masked per byte lane

`default_nettype none

`include "cache_macros.svh"

module cache_data_store (
    input  logic                 CLK,
    input  cache_pkg::set_idx_t  index,
    input  cache_pkg::word_sel_t word_sel,
    input  logic                 wr_en,
    input  cache_pkg::byte_sel_t byte_en,
    input  cache_pkg::word_t     wr_data,
    output cache_pkg::word_t     rd_data
);

    localparam int LANE_W = `WORD_W / `SEL_W;   // bits per byte lane

    cache_pkg::word_t line_q [`N_SETS][`LINE_WORDS];

    // refill enables all lanes, write hits pass the cpu selects
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            for (int b = 0; b < `SEL_W; b++) begin
                if (byte_en[b])
                    line_q[index][word_sel][b*LANE_W +: LANE_W] <= wr_data[b*LANE_W +: LANE_W];
            end
        end
    end

    assign rd_data = line_q[index][word_sel];

endmodule

`default_nettype wire

// ==== design/cache_ctrl.sv ====
// cache controller
// state machine for init, hits, victim write-back, line refill and
// flush; drives both stores and the Wishbone master toward memory

`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  flush,
    output logic                  flush_done,
    // processor side
    input  logic                  cpu_cyc,
    input  logic                  cpu_stb,
    input  logic                  cpu_we,
    input  cache_pkg::addr_t      cpu_adr,
    input  cache_pkg::word_t      cpu_dat_w,
    input  cache_pkg::byte_sel_t  cpu_sel,
    output logic                  cpu_ack,
    output cache_pkg::word_t      cpu_dat_r,
    // memory side
    output logic                  mem_cyc,
    output logic                  mem_stb,
    output logic                  mem_we,
    output cache_pkg::addr_t      mem_adr,
    output cache_pkg::word_t      mem_dat_w,
    input  logic                  mem_ack,
    input  cache_pkg::word_t      mem_dat_r,
    // store control
    output cache_pkg::set_idx_t   st_index,
    output cache_pkg::word_sel_t  st_word_sel,
    output cache_pkg::tag_t       lookup_tag,
    output logic                  tag_wr_en,
    output cache_pkg::tag_t       wr_tag,
    output logic                  wr_valid,
    output logic                  wr_dirty,
    output logic                  data_wr_en,
    output cache_pkg::byte_sel_t  data_byte_en,
    output cache_pkg::word_t      data_wr_data,
    // store status
    input  logic                  hit,
    input  cache_pkg::tag_t       line_tag,
    input  logic                  line_dirty,
    input  cache_pkg::word_t      rd_data
);

    localparam int OFS_BITS = `WORD_SEL_BITS + `BYTE_BITS;

    cache_pkg::cache_state_t state_q, state_d;
    cache_pkg::word_sel_t    word_cnt_q, word_cnt_d;    // word within a line transfer
    cache_pkg::set_idx_t     set_cnt_q, set_cnt_d;      // set walk for init and flush
    logic                    flush_req_q, flush_req_d;
    cache_pkg::addr_t        line_adr_q, line_adr_d;    // line base for refill and write-back

    cache_pkg::tag_t         req_tag;
    cache_pkg::set_idx_t     req_idx;
    cache_pkg::word_sel_t    req_word;
    cache_pkg::addr_t        line_base;
    logic                    req;
    logic                    flush_pend;
    logic                    last_word;
    logic                    last_set;

    // request address fields
    assign req_tag  = cpu_adr[`ADDR_W-1 -: `TAG_BITS];
    assign req_idx  = cpu_adr[OFS_BITS +: `SET_BITS];
    assign req_word = cpu_adr[`BYTE_BITS +: `WORD_SEL_BITS];

    assign req        = cpu_cyc & cpu_stb;
    assign flush_pend = flush | flush_req_q;
    assign last_word  = (word_cnt_q == cache_pkg::word_sel_t'(`LINE_WORDS - 1));
    assign last_set   = (set_cnt_q == cache_pkg::set_idx_t'(`N_SETS - 1));

    // store addressing
    assign lookup_tag  = req_tag;
    assign st_index    = (state_q == cache_pkg::INIT || state_q == cache_pkg::FLUSH)
                         ? set_cnt_q : req_idx;
    assign st_word_sel = (state_q == cache_pkg::READY) ? req_word : word_cnt_q;

    assign cpu_dat_r = rd_data;
    assign mem_dat_w = rd_data;    // write-back word comes straight from the store

    // flush takes the victim tag from the store, other transfers the latched line
    assign line_base = (state_q == cache_pkg::FLUSH)
                       ? {line_tag, set_cnt_q, {OFS_BITS{1'b0}}} : line_adr_q;
    assign mem_adr   = {line_base[`ADDR_W-1:OFS_BITS], word_cnt_q, {`BYTE_BITS{1'b0}}};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state_q     <= cache_pkg::INIT;
            word_cnt_q  <= '0;
            set_cnt_q   <= '0;
            flush_req_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            word_cnt_q  <= word_cnt_d;
            set_cnt_q   <= set_cnt_d;
            flush_req_q <= flush_req_d;
        end
    end

    always_ff @(posedge CLK) begin
        line_adr_q <= line_adr_d;
    end

    always_comb begin
        state_d      = state_q;
        word_cnt_d   = word_cnt_q;
        set_cnt_d    = set_cnt_q;
        flush_req_d  = flush_req_q | flush;  // hold a flush until READY takes it
        line_adr_d   = line_adr_q;
        cpu_ack      = 1'b0;
        flush_done   = 1'b0;
        mem_cyc      = 1'b0;
        mem_stb      = 1'b0;
        mem_we       = 1'b0;
        tag_wr_en    = 1'b0;
        wr_tag       = '0;
        wr_valid     = 1'b0;
        wr_dirty     = 1'b0;
        data_wr_en   = 1'b0;
        data_byte_en = '1;
        data_wr_data = mem_dat_r;

        case (state_q)
            cache_pkg::INIT: begin
                tag_wr_en = 1'b1;                   // invalidate one set per cycle
                set_cnt_d = set_cnt_q + 1'b1;
                if (last_set)
                    state_d = cache_pkg::READY;
            end
            cache_pkg::READY: begin
                if (flush_pend) begin
                    // flush goes before any new request
                    flush_req_d = 1'b0;
                    state_d     = cache_pkg::FLUSH;
                end else if (req && hit) begin
                    cpu_ack = 1'b1;
                    if (cpu_we) begin
                        tag_wr_en    = 1'b1;
                        wr_tag       = req_tag;
                        wr_valid     = 1'b1;
                        wr_dirty     = 1'b1;
                        data_wr_en   = 1'b1;
                        data_byte_en = cpu_sel;
                        data_wr_data = cpu_dat_w;
                    end
                end else if (req) begin
                    if (line_dirty) begin
                        line_adr_d = {line_tag, req_idx, {OFS_BITS{1'b0}}};    // victim line
                        state_d    = cache_pkg::WRITEBACK;
                    end else begin
                        line_adr_d = {req_tag, req_idx, {OFS_BITS{1'b0}}};
                        state_d    = cache_pkg::REFILL;
                    end
                end
            end
            cache_pkg::WRITEBACK: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                mem_we  = 1'b1;
                if (mem_ack) begin
                    word_cnt_d = word_cnt_q + 1'b1;
                    if (last_word) begin
                        // victim now clean, refill follows
                        tag_wr_en  = 1'b1;
                        wr_tag     = line_tag;
                        wr_valid   = 1'b1;
                        line_adr_d = {req_tag, req_idx, {OFS_BITS{1'b0}}};
                        state_d    = cache_pkg::REFILL;
                    end
                end
            end
            cache_pkg::REFILL: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                if (mem_ack) begin
                    data_wr_en = 1'b1;              // all lanes, memory word
                    word_cnt_d = word_cnt_q + 1'b1;
                    if (last_word) begin
                        tag_wr_en = 1'b1;
                        wr_tag    = line_adr_q[`ADDR_W-1 -: `TAG_BITS];
                        wr_valid  = 1'b1;
                        state_d   = cache_pkg::READY;
                    end
                end
            end
            cache_pkg::FLUSH: begin
                if (line_dirty) begin
                    mem_cyc = 1'b1;
                    mem_stb = 1'b1;
                    mem_we  = 1'b1;
                    if (mem_ack) begin
                        word_cnt_d = word_cnt_q + 1'b1;
                        if (last_word) begin
                            tag_wr_en = 1'b1;       // line out, invalidate it
                            set_cnt_d = set_cnt_q + 1'b1;
                        end
                    end
                end else begin
                    // clean or invalid set takes one cycle
                    tag_wr_en = 1'b1;
                    set_cnt_d = set_cnt_q + 1'b1;
                end
                if (tag_wr_en && last_set) begin
                    flush_done = 1'b1;
                    state_d    = cache_pkg::READY;
                end
            end
            default: state_d = cache_pkg::INIT;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
// L1 data cache top
// direct-mapped write-back cache, Wishbone classic slave toward
// the processor and Wishbone classic master toward memory

`default_nettype none

`include "cache_macros.svh"

module l1_cache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    output logic                 flush_done,
    // processor side
    input  logic                 cpu_cyc,
    input  logic                 cpu_stb,
    input  logic                 cpu_we,
    input  cache_pkg::addr_t     cpu_adr,
    input  cache_pkg::word_t     cpu_dat_w,
    input  cache_pkg::byte_sel_t cpu_sel,
    output logic                 cpu_ack,
    output cache_pkg::word_t     cpu_dat_r,
    // memory side
    output logic                 mem_cyc,
    output logic                 mem_stb,
    output logic                 mem_we,
    output cache_pkg::addr_t     mem_adr,
    output cache_pkg::word_t     mem_dat_w,
    input  logic                 mem_ack,
    input  cache_pkg::word_t     mem_dat_r
);

    cache_pkg::set_idx_t  st_index;
    cache_pkg::word_sel_t st_word_sel;
    cache_pkg::tag_t      lookup_tag;
    logic                 tag_wr_en;
    cache_pkg::tag_t      wr_tag;
    logic                 wr_valid;
    logic                 wr_dirty;
    logic                 data_wr_en;
    cache_pkg::byte_sel_t data_byte_en;
    cache_pkg::word_t     data_wr_data;
    logic                 hit;
    cache_pkg::tag_t      line_tag;
    logic                 line_dirty;
    cache_pkg::word_t     rd_data;

    cache_ctrl ctrl_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .flush_done   (flush_done),
        .cpu_cyc      (cpu_cyc),
        .cpu_stb      (cpu_stb),
        .cpu_we       (cpu_we),
        .cpu_adr      (cpu_adr),
        .cpu_dat_w    (cpu_dat_w),
        .cpu_sel      (cpu_sel),
        .cpu_ack      (cpu_ack),
        .cpu_dat_r    (cpu_dat_r),
        .mem_cyc      (mem_cyc),
        .mem_stb      (mem_stb),
        .mem_we       (mem_we),
        .mem_adr      (mem_adr),
        .mem_dat_w    (mem_dat_w),
        .mem_ack      (mem_ack),
        .mem_dat_r    (mem_dat_r),
        .st_index     (st_index),
        .st_word_sel  (st_word_sel),
        .lookup_tag   (lookup_tag),
        .tag_wr_en    (tag_wr_en),
        .wr_tag       (wr_tag),
        .wr_valid     (wr_valid),
        .wr_dirty     (wr_dirty),
        .data_wr_en   (data_wr_en),
        .data_byte_en (data_byte_en),
        .data_wr_data (data_wr_data),
        .hit          (hit),
        .line_tag     (line_tag),
        .line_dirty   (line_dirty),
        .rd_data      (rd_data)
    );

    cache_tag_store tags_i (
        .CLK        (CLK),
        .index      (st_index),
        .lookup_tag (lookup_tag),
        .wr_en      (tag_wr_en),
        .wr_tag     (wr_tag),
        .wr_valid   (wr_valid),
        .wr_dirty   (wr_dirty),
        .hit        (hit),
        .line_tag   (line_tag),
        .line_dirty (line_dirty)
    );

    cache_data_store data_i (
        .CLK      (CLK),
        .index    (st_index),
        .word_sel (st_word_sel),
        .wr_en    (data_wr_en),
        .byte_en  (data_byte_en),
        .wr_data  (data_wr_data),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
// Wishbone classic memory model
// 4K words filled from the address, one ack per word after
// 0 to 3 wait states drawn from a linear congruential generator

`default_nettype none

module mem_model (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    output logic        ack,
    output logic [31:0] dat_r
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [4096];
    logic [31:0] rng_q;
    logic [1:0]  wait_q;    // stalls left before the next ack
    logic [11:0] idx;

    assign idx = adr[13:2];

    // every bit of the word index shows up in the fill
    function automatic logic [31:0] fill_word(input logic [11:0] i);
        return {4'ha, i, 4'h5, i};
    endfunction

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++)
            mem[i] = fill_word(12'(i));
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack    <= 1'b0;
            dat_r  <= '0;
            wait_q <= 2'd0;
            rng_q  <= 32'hb169;
        end else begin
            ack <= 1'b0;                        // one cycle, next word follows
            if (cyc && stb && !ack) begin
                if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 2'd1;
                end else begin
                    ack    <= 1'b1;
                    rng_q  <= lcg_step(rng_q);
                    wait_q <= rng_q[17:16];     // stalls for the next word
                    if (we)
                        mem[idx] <= dat_w;
                    else
                        dat_r <= mem[idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/l1_cache_tb.sv ====
// L1 cache testbench
// reads, byte writes, victim write-back, flush and random traffic
// against a shadow memory, with bus rule checks every cycle

`default_nettype none

module l1_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 1000;   // cycles allowed per wait

    logic        CLK, nRST, flush, flush_done;
    logic        cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    logic [31:0] cpu_adr, cpu_dat_w, cpu_dat_r;
    logic [3:0]  cpu_sel;
    logic        mem_cyc, mem_stb, mem_we, mem_ack;
    logic [31:0] mem_adr, mem_dat_w, mem_dat_r;

    logic [31:0] shadow [4096];
    int unsigned written [$];           // word indexes hit by writes
    int          errors = 0;
    int          bus_errs = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          done_pulses = 0;
    int          beat = 0;              // word within a line transfer
    logic [31:0] line_start, last_adr, last_dat;
    logic        last_wait;

    l1_cache dut_i (.*);

    mem_model mem_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_w (mem_dat_w),
        .ack   (mem_ack),
        .dat_r (mem_dat_r)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // selected lanes from nw, old value elsewhere
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] nw, input logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (sel[b])
                res[b*8 +: 8] = nw[b*8 +: 8];
        return res;
    endfunction

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp)
        else begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic bus_fault(input string what);
        $display("bus rule broken at %0d ns: %s", $time, what);
        bus_errs++;
    endtask

    // one classic request, held until cpu_ack
    task automatic cpu_transfer(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                                input logic [3:0] sel, output logic [31:0] rdat);
        logic acked;
        acked = 1'b0;
        @(posedge CLK);
        #2;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_dat_w = dat;
        cpu_sel   = sel;
        for (int n = 0; n < WAIT_LIMIT && !acked; n++) begin
            @(negedge CLK);
            acked = cpu_ack;
            rdat  = cpu_dat_r;
        end
        @(posedge CLK);
        #2;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
        if (!acked) begin
            $display("timeout: no cpu_ack for address %h within %0d cycles", adr, WAIT_LIMIT);
            errors++;
        end else if (we) begin
            shadow[adr[13:2]] = merge_bytes(shadow[adr[13:2]], dat, sel);
            written.push_back(adr[13:2]);
        end
    endtask

    task automatic read_check(input logic [31:0] adr);
        logic [31:0] rd;
        cpu_transfer(1'b0, adr, '0, 4'h0, rd);
        check_word(rd, shadow[adr[13:2]], $sformatf("read of %h", adr));
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
        logic [31:0] rd;
        cpu_transfer(1'b1, adr, dat, sel, rd);
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    // bus rules, sampled mid-cycle where everything is settled
    always @(negedge CLK) begin
        if (!nRST) begin
            assert (!cpu_ack && !mem_cyc && !mem_stb && !flush_done)
            else bus_fault("outputs not idle in reset");
        end else begin
            assert (!mem_stb || mem_cyc) else bus_fault("mem_stb high without mem_cyc");
            assert (!cpu_ack || cpu_stb) else bus_fault("cpu_ack high without cpu_stb");
            assert (!mem_stb || mem_adr[1:0] == 2'b00) else bus_fault("mem_adr not word aligned");
            assert (!last_wait || (mem_stb && mem_adr == last_adr
                                   && (!mem_we || mem_dat_w == last_dat)))
            else bus_fault("memory request changed before mem_ack");
            if (mem_stb && mem_ack) begin
                if (beat == 0)
                    line_start = mem_adr;
                assert (line_start[3:0] == 4'h0 && mem_adr == line_start + 32'(beat * 4))
                else bus_fault("line transfer not consecutive from a line boundary");
                beat = (beat + 1) % 4;
            end
            assert (mem_cyc || beat == 0) else bus_fault("mem_cyc dropped inside a line");
            if (flush_done)
                done_pulses++;
        end
        last_wait = mem_stb && !mem_ack;
        last_adr  = mem_adr;
        last_dat  = mem_dat_w;
    end

    initial begin
        logic [31:0] rng;
        logic [31:0] a;
        logic        seen;
        int          start;
        nRST      = 1'b0;
        flush     = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        cpu_sel   = '0;
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;
        for (int i = 0; i < 4096; i++)
            shadow[i] = mem_i.mem[i];   // shadow starts from the memory fill

        start = errors;
        read_check(32'h000);            // waits out INIT too
        read_check(32'h014);
        read_check(32'h128);
        read_check(32'h23c);
        read_check(32'h004);            // hit on the first line
        finish_test("first reads after reset", errors - start);

        start = errors;
        read_check(32'h040);
        write_word(32'h044, 32'h1122_3344, 4'b0001);
        read_check(32'h044);
        write_word(32'h044, 32'h5566_7788, 4'b0011);
        read_check(32'h044);
        write_word(32'h048, 32'h99aa_bbcc, 4'b1100);
        read_check(32'h048);
        write_word(32'h04c, 32'hddee_ff00, 4'b1111);
        read_check(32'h04c);
        finish_test("byte select writes", errors - start);

        start = errors;
        write_word(32'h088, 32'hcafe_f00d, 4'b1111);
        read_check(32'h188);            // same set, other tag
        for (int k = 0; k < 4; k++)
            check_word(mem_i.mem[32 + k], shadow[32 + k], $sformatf("memory word %0d", 32 + k));
        finish_test("dirty victim write-back", errors - start);

        start = errors;
        write_word(32'h0c4, 32'h0bad_beef, 4'b1111);
        write_word(32'h1d8, 32'h1234_5678, 4'b0110);
        write_word(32'h2ec, 32'hfeed_0001, 4'b1111);
        write_word(32'h3f0, 32'h7777_8888, 4'b1001);
        @(posedge CLK);
        #2;
        flush = 1'b1;
        @(posedge CLK);
        #2;
        flush = 1'b0;
        seen = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
            @(negedge CLK);
            seen = flush_done;
        end
        if (!seen) begin
            $display("timeout: no flush_done within %0d cycles", WAIT_LIMIT);
            errors++;
        end
        foreach (written[i])
            check_word(mem_i.mem[written[i]], shadow[written[i]],
                       $sformatf("memory word %0d", written[i]));
        foreach (written[i])
            read_check(32'(written[i] * 4));
        check_word(32'(done_pulses), 32'd1, "flush_done pulse count");
        finish_test("flush", errors - start);

        start = errors;
        rng = 32'hb169;
        for (int n = 0; n < 200; n++) begin
            rng = next_rand(rng);
            a   = {22'd0, rng[23:16], 2'b00};   // 256 words over 64 lines
            if (rng[31])
                write_word(a, next_rand(rng), rng[11:8]);
            else
                read_check(a);
        end
        finish_test("random mixed traffic", errors - start);
        finish_test("memory bus rules", bus_errs);

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors + bus_errs);
        if (errors == 0 && bus_errs == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/l1_cache.sv
sim/mem_model.sv
sim/l1_cache_tb.sv
